/* bench/noncomp_tb.sv */
module noncomp_tb;

  import noncomp_pkg::*;

  logic         clk_i = 1'b0;
  logic         arst_n_i;
  logic         in_valid_i;
  logic         in_ready_o;
  noncomp_req_t req_i;
  logic         out_valid_o;
  logic         out_ready_i;
  noncomp_rsp_t rsp_o;

  // Vector storage, one entry per test
  string        names[$];
  noncomp_req_t reqs[$];
  noncomp_rsp_t exps[$];
  // Indices of accepted requests awaiting a response
  int           pending[$];

  int           error_count  = 0;
  int           rsp_count    = 0;
  int           tests_passed = 0;
  int           tests_failed = 0;
  bit           loaded       = 1'b0;
  logic [31:0]  rng_state    = 32'd66;

  noncomp_top i_dut (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .in_valid_i  ( in_valid_i  ),
    .in_ready_o  ( in_ready_o  ),
    .req_i       ( req_i       ),
    .out_valid_o ( out_valid_o ),
    .out_ready_i ( out_ready_i ),
    .rsp_o       ( rsp_o       )
  );

  // 8 unit period
  always #4 clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string test_name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error: test %s, %s expected %0h actual %0h",
               test_name, field, expected, actual);
      error_count++;
    end
  endtask

  // Comment lines start with #
  task automatic load_vectors();
    int           fd;
    int           code;
    string        line;
    string        name_v;
    logic [31:0]  f_op, f_rm, f_mod, f_a, f_b;
    logic [31:0]  f_res, f_st, f_ext, f_cls, f_isc;
    noncomp_req_t req_v;
    noncomp_rsp_t exp_v;
    fd = $fopen("bench/noncomp_vectors.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", name_v, f_op, f_rm,
                         f_mod, f_a, f_b, f_res, f_st, f_ext, f_cls, f_isc);
          if (code == 11) begin
            req_v.op            = op_e'(f_op[1:0]);
            req_v.rnd_mode      = rm_e'(f_rm[2:0]);
            req_v.op_mod        = f_mod[0];
            req_v.operand_a.raw = f_a;
            req_v.operand_b.raw = f_b;
            exp_v.result        = f_res;
            exp_v.status        = f_st[4:0];
            exp_v.ext_bit       = f_ext[0];
            exp_v.class_mask    = class_mask_e'(f_cls[9:0]);
            exp_v.is_class      = f_isc[0];
            names.push_back(name_v);
            reqs.push_back(req_v);
            exps.push_back(exp_v);
          end
        end
      end
      $fclose(fd);
    end
    if (reqs.size() == 0) begin
      $display("No test vectors could be read from bench/noncomp_vectors.txt");
      error_count++;
    end
  endtask

  // ----------------------------------------
  // Back-pressure, about 70 percent ready
  // ----------------------------------------
  always @(posedge clk_i) begin
    #1;
    rng_state   = xorshift32(rng_state);
    out_ready_i = (rng_state % 10) < 7;
  end

  // ----------------------------------------
  // Response monitor
  // ----------------------------------------
  // Sampled at the falling edge, where handshake signals are settled
  always @(negedge clk_i) begin : monitor
    int idx;
    int errs_before;
    if (!arst_n_i) begin
      check_value("reset", "out_valid_o", 64'd0, out_valid_o);
    end else if (out_valid_o && out_ready_i) begin
      if (pending.size() == 0) begin
        $display("A response arrived with no request outstanding");
        error_count++;
      end else begin
        idx         = pending.pop_front();
        errs_before = error_count;
        check_value(names[idx], "result", exps[idx].result, rsp_o.result);
        check_value(names[idx], "status", exps[idx].status, rsp_o.status);
        check_value(names[idx], "ext_bit", exps[idx].ext_bit, rsp_o.ext_bit);
        check_value(names[idx], "class_mask", exps[idx].class_mask, rsp_o.class_mask);
        check_value(names[idx], "is_class", exps[idx].is_class, rsp_o.is_class);
        if (error_count == errs_before) begin
          $display("test %-18s ok", names[idx]);
          tests_passed++;
        end else begin
          $display("test %-18s mismatch", names[idx]);
          tests_failed++;
        end
        rsp_count++;
      end
    end
  end

  // Limit scales with the number of vectors
  initial begin : watchdog
    wait (loaded);
    wait (arst_n_i);
    repeat (reqs.size() * 20 + 100) @(posedge clk_i);
    $display("Watchdog expired, responses stopped arriving after %0d of %0d",
             rsp_count, reqs.size());
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Reset and request driver
  // ----------------------------------------
  initial begin : main_seq
    bit accepted;
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    req_i       = '0;
    out_ready_i = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (10) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    // Register must come out of reset empty and cleared
    @(negedge clk_i);
    check_value("reset", "out_valid_o after reset", 64'd0, out_valid_o);
    check_value("reset", "rsp_o after reset", 64'd0, rsp_o);
    @(posedge clk_i);
    #1;
    for (int i = 0; i < reqs.size(); i++) begin
      in_valid_i = 1'b1;
      req_i      = reqs[i];
      accepted   = 1'b0;
      // Hold the request until the next edge takes it
      while (!accepted) begin
        @(negedge clk_i);
        // Output register is full while an accepted request awaits its response
        check_value("handshake", "in_ready_o", out_ready_i || pending.size() == 0,
                    in_ready_o);
        if (in_ready_o) begin
          accepted = 1'b1;
          pending.push_back(i);
        end
        @(posedge clk_i);
        #1;
      end
    end
    in_valid_i = 1'b0;
    req_i      = '0;
    wait (rsp_count == reqs.size());
    // Extra cycles catch duplicated responses
    repeat (5) @(posedge clk_i);
    check_value("handshake", "response count", reqs.size(), rsp_count);
    $display("%0d tests, %0d responses, %0d passed, %0d failed, %0d errors",
             reqs.size(), rsp_count, tests_passed, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* bench/noncomp_vectors.txt */
# name op rm op_mod operand_a operand_b | expected: result status ext_bit class_mask is_class
# all fields hex; status bit 4 is nv; class_mask is the class of operand_a
sgnj_pos_neg       0 0 0 3f800000 c0000000 bf800000 00 1 040 0
sgnjn_pos_neg      0 1 0 3f800000 c0000000 3f800000 00 1 040 0
sgnjx_neg_neg      0 2 0 bf800000 c0000000 3f800000 00 1 002 0
sgnjx_neg_pos_mod  0 2 1 bf800000 40000000 bf800000 00 1 002 0
sgnj_pass_mod      0 3 1 3fc00000 bf800000 3fc00000 00 0 040 0
min_ordinary       1 0 0 3f800000 40000000 3f800000 00 1 040 0
max_ordinary       1 1 0 3f800000 40000000 40000000 00 1 040 0
max_negatives      1 1 0 c0000000 bf800000 bf800000 00 1 002 0
min_zeros          1 0 0 80000000 00000000 80000000 00 1 008 0
max_zeros          1 1 0 80000000 00000000 00000000 00 1 008 0
min_qnan_a         1 0 0 7fc00000 3f800000 3f800000 00 1 200 0
min_two_nans       1 0 0 7fc00000 ffc00000 7fc00000 00 1 200 0
max_snan_a         1 1 0 7f800001 3f800000 3f800000 10 1 100 0
le_equal           2 0 0 3f800000 3f800000 00000001 00 0 040 0
lt_equal           2 1 0 3f800000 3f800000 00000000 00 0 040 0
eq_equal_mod       2 2 1 3f800000 3f800000 00000000 00 0 040 0
lt_zeros           2 1 0 00000000 80000000 00000000 00 0 010 0
eq_zeros           2 2 0 00000000 80000000 00000001 00 0 010 0
lt_negatives       2 1 0 c0000000 bf800000 00000001 00 0 002 0
le_negatives_mod   2 0 1 bf800000 c0000000 00000001 00 0 002 0
le_qnan            2 0 0 7fc00000 3f800000 00000000 10 0 200 0
lt_qnan_mod        2 1 1 3f800000 7fc00000 00000000 10 0 040 0
eq_qnan_mod        2 2 1 3f800000 7fc00000 00000001 00 0 040 0
eq_snan_mod        2 2 1 7f800001 3f800000 00000000 10 0 100 0
cls_neginf         3 0 0 ff800000 00000000 00000000 00 0 001 1
cls_negnorm        3 0 0 bf800000 00000000 00000000 00 0 002 1
cls_negsubnorm     3 0 0 80000001 00000000 00000000 00 0 004 1
cls_negzero        3 0 0 80000000 00000000 00000000 00 0 008 1
cls_poszero        3 0 0 00000000 00000000 00000000 00 0 010 1
cls_possubnorm     3 0 0 007fffff 00000000 00000000 00 0 020 1
cls_posnorm        3 0 0 3f800000 00000000 00000000 00 0 040 1
cls_posinf         3 0 0 7f800000 00000000 00000000 00 0 080 1
cls_snan           3 0 0 7fa00000 00000000 00000000 00 0 100 1
cls_qnan           3 0 0 ffc00001 00000000 00000000 00 0 200 1

/* design/noncomp_compare.sv */
module noncomp_compare (
  input  noncomp_pkg::noncomp_req_t req_i,
  output noncomp_pkg::unit_res_t    minmax_o,
  output noncomp_pkg::unit_res_t    cmp_o
);

  import noncomp_pkg::*;

  // ----------------------------------------
  // Operand decode
  // ----------------------------------------
  fp32_u    operand_a;
  fp32_u    operand_b;
  fp_info_t info_a;
  fp_info_t info_b;

  logic any_nan;
  logic signalling_nan;
  logic operands_equal;
  logic operand_a_smaller;
  logic cmp_bool;

  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;
  assign info_a    = classify_fp(operand_a.fields);
  assign info_b    = classify_fp(operand_b.fields);

  // Special case reductions
  assign any_nan        = info_a.is_nan | info_b.is_nan;
  assign signalling_nan = info_a.is_signalling | info_b.is_signalling;

  // Zeros of opposite sign count as equal
  assign operands_equal = (operand_a.raw == operand_b.raw) ||
                          (info_a.is_zero && info_b.is_zero);

  // Raw unsigned compare, flipped when a sign bit is involved
  assign operand_a_smaller = (operand_a.raw < operand_b.raw) ^
                             (operand_a.fields.sign || operand_b.fields.sign);

  // ----------------------------------------
  // Minimum / maximum
  // ----------------------------------------
  // RNE is MIN, RTZ is MAX
  always_comb begin : min_max
    minmax_o         = '0;
    // Quiet compare, only sNaN is invalid
    minmax_o.status.nv = signalling_nan;
    // Result always lands in a float register
    minmax_o.ext_bit = 1'b1;
    if (info_a.is_nan && info_b.is_nan) begin
      minmax_o.result = CANONICAL_NAN;
    end else if (info_a.is_nan) begin
      minmax_o.result = operand_b.raw;
    end else if (info_b.is_nan) begin
      minmax_o.result = operand_a.raw;
    end else if (req_i.rnd_mode == RM_RTZ) begin
      minmax_o.result = operand_a_smaller ? operand_b.raw : operand_a.raw;
    end else begin
      minmax_o.result = operand_a_smaller ? operand_a.raw : operand_b.raw;
    end
  end

  // ----------------------------------------
  // Comparisons
  // ----------------------------------------
  // RNE is LE, RTZ is LT, RDN is EQ
  // op_mod inverts the boolean
  always_comb begin : comparisons
    cmp_o    = '0;
    cmp_bool = 1'b0;
    if (signalling_nan) begin
      // sNaN compares false and is invalid for every compare
      cmp_o.status.nv = 1'b1;
    end else begin
      case (req_i.rnd_mode)
        RM_RNE: begin
          // Signalling compare, any NaN is invalid
          if (any_nan) cmp_o.status.nv = 1'b1;
          else cmp_bool = (operand_a_smaller | operands_equal) ^ req_i.op_mod;
        end
        RM_RTZ: begin
          if (any_nan) cmp_o.status.nv = 1'b1;
          else cmp_bool = (operand_a_smaller & ~operands_equal) ^ req_i.op_mod;
        end
        RM_RDN: begin
          // Quiet compare, NaN is never equal
          if (any_nan) cmp_bool = req_i.op_mod;
          else cmp_bool = operands_equal ^ req_i.op_mod;
        end
        default: cmp_bool = 1'b0;
      endcase
    end
    // Boolean in bit 0, integer destination so no extension
    cmp_o.result[0] = cmp_bool;
  end

  // Smaller and equal together only for a negative A
  // Equal negative pairs and -0 against +0 set both, LT masks that with ~equal
  a_smaller_not_equal: assert final (
    $isunknown(req_i) || any_nan ||
    !(operand_a_smaller && operands_equal) || operand_a.fields.sign
  ) else $error("noncomp_compare: positive A reported both smaller than and equal to B");

endmodule

/* design/noncomp_pkg.sv */
package noncomp_pkg;

  // ----------------------------------------
  // Format constants
  // ----------------------------------------
  // Single format only, binary32
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // Positive sign, exponent all ones, only the top mantissa bit set
  localparam logic [FP_WIDTH-1:0] CANONICAL_NAN = 32'h7fc0_0000;

  // ----------------------------------------
  // Operand word
  // ----------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp32_t;

  // Same word seen as fields or as a raw magnitude for unsigned compare
  typedef union packed {
    fp32_t               fields;
    logic [FP_WIDTH-1:0] raw;
  } fp32_u;

  // ----------------------------------------
  // Operation encodings
  // ----------------------------------------
  // Rounding-mode field, reused as sub-operation select
  typedef enum logic [2:0] {
    RM_RNE = 3'b000,
    RM_RTZ = 3'b001,
    RM_RDN = 3'b010,
    RM_RUP = 3'b011
  } rm_e;

  // Operation group
  typedef enum logic [1:0] {
    OP_SGNJ     = 2'd0,
    OP_MINMAX   = 2'd1,
    OP_CMP      = 2'd2,
    OP_CLASSIFY = 2'd3
  } op_e;

  // IEEE exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // One-hot class result, bit 0 is NEGINF
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } class_mask_e;

  // Decoded operand category
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // ----------------------------------------
  // Request and response bundles
  // ----------------------------------------
  typedef struct packed {
    op_e   op;
    rm_e   rnd_mode;
    logic  op_mod;
    fp32_u operand_a;
    fp32_u operand_b;
  } noncomp_req_t;

  // Candidate from one operation group
  typedef struct packed {
    logic [FP_WIDTH-1:0] result;
    status_t             status;
    logic                ext_bit;
  } unit_res_t;

  typedef struct packed {
    logic [FP_WIDTH-1:0] result;
    status_t             status;
    logic                ext_bit;
    class_mask_e         class_mask;
    logic                is_class;
  } noncomp_rsp_t;

  // Operand classification, shared by both side units
  function automatic fp_info_t classify_fp(input fp32_t value);
    fp_info_t info;
    logic     exp_ones;
    logic     exp_zero;
    logic     man_zero;
    exp_ones           = &value.exponent;
    exp_zero           = ~|value.exponent;
    man_zero           = ~|value.mantissa;
    info.is_normal     = ~exp_ones & ~exp_zero;
    info.is_subnormal  = exp_zero & ~man_zero;
    info.is_zero       = exp_zero & man_zero;
    info.is_inf        = exp_ones & man_zero;
    info.is_nan        = exp_ones & ~man_zero;
    // Quiet bit clear marks a signalling NaN
    info.is_signalling = info.is_nan & ~value.mantissa[MAN_BITS-1];
    return info;
  endfunction

endpackage

/* design/noncomp_result_stage.sv */
module noncomp_result_stage (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Upstream handshake
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  // Candidates from the side units
  input  noncomp_pkg::op_e          op_i,
  input  noncomp_pkg::unit_res_t    sgnj_i,
  input  noncomp_pkg::unit_res_t    minmax_i,
  input  noncomp_pkg::unit_res_t    cmp_i,
  input  noncomp_pkg::class_mask_e  class_mask_i,
  // Downstream handshake
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output noncomp_pkg::noncomp_rsp_t rsp_o
);

  import noncomp_pkg::*;

  unit_res_t    sel_res;
  noncomp_rsp_t rsp_d;
  noncomp_rsp_t rsp_q;
  logic         valid_q;
  logic         load;

  // ----------------------------------------
  // Result select
  // ----------------------------------------
  always_comb begin : select_result
    unique case (op_i)
      OP_SGNJ:     sel_res = sgnj_i;
      OP_MINMAX:   sel_res = minmax_i;
      OP_CMP:      sel_res = cmp_i;
      // Class result travels on class_mask, no flags
      OP_CLASSIFY: sel_res = '0;
    endcase
  end

  always_comb begin : build_rsp
    rsp_d.result     = sel_res.result;
    rsp_d.status     = sel_res.status;
    rsp_d.ext_bit    = sel_res.ext_bit;
    rsp_d.class_mask = class_mask_i;
    rsp_d.is_class   = (op_i == OP_CLASSIFY);
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  // Ready when empty or drained this cycle
  assign in_ready_o = out_ready_i | ~valid_q;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      // Drops to 0 when drained with nothing new arriving
      valid_q <= in_valid_i;
    end
  end

  // Response word reads as zero out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_q <= '0;
    end else if (load) begin
      rsp_q <= rsp_d;
    end
  end

  assign out_valid_o = valid_q;
  assign rsp_o       = rsp_q;

  // Stalled response must not change or vanish
  a_hold_on_stall: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(rsp_o)
  ) else $error("noncomp_result_stage: response changed under back-pressure");

  // Nothing is offered downstream while in reset
  a_idle_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> !out_valid_o
  ) else $error("noncomp_result_stage: out_valid_o high during reset");

endmodule

/* design/noncomp_sign_class.sv */
module noncomp_sign_class (
  input  noncomp_pkg::noncomp_req_t req_i,
  output noncomp_pkg::unit_res_t    sgnj_o,
  output noncomp_pkg::class_mask_e  class_mask_o
);

  import noncomp_pkg::*;

  fp32_u    operand_a;
  fp32_u    operand_b;
  fp_info_t info_a;
  fp32_u    sgnj_result;

  assign operand_a = req_i.operand_a;
  assign operand_b = req_i.operand_b;
  // Only operand A is classified here
  assign info_a    = classify_fp(operand_a.fields);

  // ----------------------------------------
  // Sign injection
  // ----------------------------------------
  // Magnitude always comes from A
  always_comb begin : sign_injection
    sgnj_result = operand_a;
    case (req_i.rnd_mode)
      // SGNJ
      RM_RNE: sgnj_result.fields.sign = operand_b.fields.sign;
      // SGNJN
      RM_RTZ: sgnj_result.fields.sign = ~operand_b.fields.sign;
      // SGNJX
      RM_RDN: sgnj_result.fields.sign = operand_a.fields.sign ^ operand_b.fields.sign;
      // Passthrough of A, sign untouched
      RM_RUP: sgnj_result = operand_a;
      default: sgnj_result = operand_a;
    endcase
  end

  assign sgnj_o.result = sgnj_result.raw;
  // Never raises flags
  assign sgnj_o.status = '0;
  // op_mod asks for integer sign extension of the result
  assign sgnj_o.ext_bit = req_i.op_mod ? sgnj_result.fields.sign : 1'b1;

  // ----------------------------------------
  // Classification
  // ----------------------------------------
  always_comb begin : classify
    if (info_a.is_normal) begin
      class_mask_o = operand_a.fields.sign ? NEGNORM : POSNORM;
    end else if (info_a.is_subnormal) begin
      class_mask_o = operand_a.fields.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a.is_zero) begin
      class_mask_o = operand_a.fields.sign ? NEGZERO : POSZERO;
    end else if (info_a.is_inf) begin
      class_mask_o = operand_a.fields.sign ? NEGINF : POSINF;
    end else if (info_a.is_nan) begin
      // NaN sign is ignored
      class_mask_o = info_a.is_signalling ? SNAN : QNAN;
    end else begin
      class_mask_o = QNAN;
    end
  end

  // Classifier categories must cover every encoding exactly once
  a_class_onehot: assert final (
    $isunknown(req_i) ||
    $onehot({info_a.is_normal, info_a.is_subnormal, info_a.is_zero,
             info_a.is_inf, info_a.is_nan})
  ) else $error("noncomp_sign_class: operand A decodes to no class or to several");

endmodule

/* design/noncomp_top.sv */
module noncomp_top (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  // Request side
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  noncomp_pkg::noncomp_req_t req_i,
  // Response side
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output noncomp_pkg::noncomp_rsp_t rsp_o
);

  import noncomp_pkg::*;

  // ----------------------------------------
  // Side unit results
  // ----------------------------------------
  unit_res_t   minmax_res;
  unit_res_t   cmp_res;
  unit_res_t   sgnj_res;
  class_mask_e class_mask;

  // Min/max and compares on A and B
  noncomp_compare i_compare (
    .req_i    ( req_i      ),
    .minmax_o ( minmax_res ),
    .cmp_o    ( cmp_res    )
  );

  // Sign injection and class of A
  noncomp_sign_class i_sign_class (
    .req_i        ( req_i      ),
    .sgnj_o       ( sgnj_res   ),
    .class_mask_o ( class_mask )
  );

  // ----------------------------------------
  // Select and register
  // ----------------------------------------
  // Single stage, one cycle latency
  noncomp_result_stage i_result_stage (
    .clk_i        ( clk_i       ),
    .arst_n_i     ( arst_n_i    ),
    .in_valid_i   ( in_valid_i  ),
    .in_ready_o   ( in_ready_o  ),
    .op_i         ( req_i.op    ),
    .sgnj_i       ( sgnj_res    ),
    .minmax_i     ( minmax_res  ),
    .cmp_i        ( cmp_res     ),
    .class_mask_i ( class_mask  ),
    .out_valid_o  ( out_valid_o ),
    .out_ready_i  ( out_ready_i ),
    .rsp_o        ( rsp_o       )
  );

endmodule

/* verilog.f */
design/noncomp_pkg.sv
design/noncomp_compare.sv
design/noncomp_sign_class.sv
design/noncomp_result_stage.sv
design/noncomp_top.sv
bench/noncomp_tb.sv
